/* alu_datapath.sv */
// alu datapath, register read addressing, operand choice and the integer operations
`timescale 1ns/1ps

module alu_datapath (
    input  alu_pkg::entry_t                entry,
    input  logic [alu_pkg::data_w-1:0]     rs_data,
    input  logic [alu_pkg::data_w-1:0]     rt_data,
    output logic [alu_pkg::reg_addr_w-1:0] rs_addr,
    output logic [alu_pkg::reg_addr_w-1:0] rt_addr,
    output logic [alu_pkg::data_w-1:0]     result
);

    logic [alu_pkg::data_w-1:0] op_b;
    logic [4:0]                 shamt;

    assign rs_addr = entry.rs;
    assign rt_addr = entry.operand.reg_form.rt;

    // immediate ops take the whole operand word, the rest read rt
    assign op_b  = alu_pkg::is_imm_op(entry.opcode) ? entry.operand.imm_form : rt_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (entry.opcode)
            alu_pkg::op_add,
            alu_pkg::op_addi: result = rs_data + op_b;
            alu_pkg::op_sub:  result = rs_data - op_b;
            alu_pkg::op_and,
            alu_pkg::op_andi: result = rs_data & op_b;
            alu_pkg::op_or,
            alu_pkg::op_ori:  result = rs_data | op_b;
            alu_pkg::op_xor:  result = rs_data ^ op_b;
            alu_pkg::op_slt:  result = (rs_data < op_b) ? '1 : '0; // unsigned compare
            alu_pkg::op_sll:  result = rs_data << shamt;
            alu_pkg::op_srl:  result = rs_data >> shamt;
            alu_pkg::op_sra:  result = $unsigned($signed(rs_data) >>> shamt); // sign fill
            default:          result = '0; // never selected
        endcase
    end

endmodule

/* alu_pkg.sv */
// alu stage package with widths, opcodes, stage codes and the slot entry layout
package alu_pkg;

    localparam int num_slots  = 8;
    localparam int slot_idx_w = 3;
    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int tag_w      = 5;
    localparam int num_tags   = 32;

    typedef logic [2:0] stage_t;            // slot stage as seen from upstream
    localparam stage_t stage_exec = 3'b100; // ready to execute
    localparam stage_t stage_wb   = 3'b001; // ready to write back

    typedef logic [2:0] stamp_t;            // bit 2 executed, bit 0 written back

    typedef logic [5:0] opcode_t;
    localparam opcode_t op_add  = 6'b000000;
    localparam opcode_t op_sub  = 6'b000001;
    localparam opcode_t op_and  = 6'b000010;
    localparam opcode_t op_or   = 6'b000011;
    localparam opcode_t op_xor  = 6'b000100;
    localparam opcode_t op_slt  = 6'b000101; // unsigned, all ones when true
    localparam opcode_t op_addi = 6'b000110;
    localparam opcode_t op_andi = 6'b000111;
    localparam opcode_t op_ori  = 6'b001000;
    localparam opcode_t op_sll  = 6'b010110;
    localparam opcode_t op_srl  = 6'b010111;
    localparam opcode_t op_sra  = 6'b011000;

    // second operand word, either a register address or a full immediate
    typedef union packed {
        struct packed {
            logic [data_w-reg_addr_w-1:0] unused;
            logic [reg_addr_w-1:0]        rt;
        } reg_form;
        logic [data_w-1:0] imm_form;
    } operand_u;

    typedef struct packed {
        opcode_t               opcode;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rd;
        operand_u              operand;
        logic [tag_w-1:0]      tag;      // result buffer slot, set by execute
        stamp_t                stamp;
    } entry_t;

    function automatic logic is_imm_op(opcode_t op);
        return op inside {op_addi, op_andi, op_ori};
    endfunction

    function automatic logic is_alu_op(opcode_t op);
        logic reg_op;
        reg_op = op inside {op_add, op_sub, op_and, op_or, op_xor, op_slt,
                            op_sll, op_srl, op_sra};
        return reg_op || is_imm_op(op);
    endfunction

endpackage

/* alu_result_buffer.sv */
// result buffer, holds executed results by tag until writeback reads them
`timescale 1ns/1ps

module alu_result_buffer (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [alu_pkg::tag_w-1:0]     wr_tag,
    input  logic [alu_pkg::data_w-1:0]    wr_data,
    input  logic [alu_pkg::tag_w-1:0]     rd_tag,
    output logic [alu_pkg::data_w-1:0]    rd_data
);

    logic [alu_pkg::data_w-1:0] mem [alu_pkg::num_tags];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_tag] <= wr_data; // parked at the edge after execute
        end
    end

    assign rd_data = mem[rd_tag]; // same cycle read for writeback

endmodule

/* alu_slot_select.sv */
// slot picker that chooses one execute slot and one writeback slot by highest index
`timescale 1ns/1ps

module alu_slot_select (
    input  alu_pkg::stage_t [alu_pkg::num_slots-1:0] slot_stage,
    input  alu_pkg::entry_t [alu_pkg::num_slots-1:0] slot_entry,
    input  logic                                     exec_allow,
    output logic                                     exec_fire,
    output logic [alu_pkg::slot_idx_w-1:0]           exec_slot,
    output logic                                     wb_pick,
    output logic [alu_pkg::slot_idx_w-1:0]           wb_slot
);

    logic exec_pick;

    always_comb begin
        exec_pick = 1'b0;
        exec_slot = '0;
        for (int i = alu_pkg::num_slots - 1; i >= 0; i--) begin
            if (!exec_pick && slot_stage[i] == alu_pkg::stage_exec &&
                alu_pkg::is_alu_op(slot_entry[i].opcode)) begin
                exec_pick = 1'b1;
                exec_slot = i[alu_pkg::slot_idx_w-1:0];
            end
        end
    end

    always_comb begin
        wb_pick = 1'b0;
        wb_slot = '0;
        for (int i = alu_pkg::num_slots - 1; i >= 0; i--) begin
            if (!wb_pick && slot_stage[i] == alu_pkg::stage_wb) begin
                wb_pick = 1'b1;
                wb_slot = i[alu_pkg::slot_idx_w-1:0];
            end
        end
    end

    assign exec_fire = exec_pick && exec_allow; // held back while next tag is busy

endmodule

/* alu_tag_tracker.sv */
// tag tracker, hands out buffer tags in rotation and marks each busy until written back
`timescale 1ns/1ps

module alu_tag_tracker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alloc,
    input  logic                      release_en,
    input  logic [alu_pkg::tag_w-1:0] release_tag,
    output logic [alu_pkg::tag_w-1:0] next_tag,
    output logic                      next_free
);

    logic [alu_pkg::tag_w-1:0]    ptr;
    logic [alu_pkg::num_tags-1:0] busy;

    assign next_tag  = ptr;
    assign next_free = !busy[ptr]; // pointer waits on a busy tag

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr  <= '0;
            busy <= '0;
        end else begin
            if (release_en) begin
                busy[release_tag] <= 1'b0;
            end
            if (alloc) begin
                busy[ptr] <= 1'b1;
                ptr       <= ptr + 1'b1; // wraps after tag 31
            end
        end
    end

    // a tag is handed out only when its previous result has left
    assert property (@(posedge clk) disable iff (rst) alloc |-> next_free)
        else $error("tag %0d allocated while still busy", ptr);

    // writeback only returns tags that execute gave out
    assert property (@(posedge clk) disable iff (rst) release_en |-> busy[release_tag])
        else $error("tag %0d released while free", release_tag);

endmodule

/* alu_trace.txt */
# cnt rst stages slot op rs rd operand tag st rs_data rt_data rdy
#   then expected: take_valid take_tag stamp_valid stamp wb_valid wb_addr wb_data
# idle after reset
2 0 00000000 0 00 00 00 00000000 00 0 00000000 00000000 1 00 00 00 000000 0 00 00000000
# slots 6 and 2 ready to execute, slot 6 wins
1 0 04000400 6 00 01 01 00000000 00 0 00000001 00000002 1 40 00 40 100000 0 00 00000000
# slot 7 has an unsupported opcode, slot 3 is taken
1 0 40004000 7 3f 01 01 00000000 00 0 00000001 00000002 1 08 01 08 000800 0 00 00000000
# operations, each executes and then writes back in the next line
1 0 00000040 1 00 01 02 00000003 02 0 00000005 00000003 1 02 02 02 000020 0 00 00000000
1 0 00000014 0 01 01 03 00000004 03 0 00000003 00000005 1 01 03 03 00000c 1 02 00000008
1 0 00000041 1 02 01 04 00000004 04 0 f0f0f0f0 ff00ff00 1 02 04 03 000021 1 03 fffffffe
1 0 00000014 0 03 01 05 00000004 05 0 0f000000 000000f0 1 01 05 03 00000c 1 04 f000f000
1 0 00000041 1 04 01 06 00000004 06 0 ffff0000 0f0f0f0f 1 02 06 03 000021 1 05 0f0000f0
1 0 00000014 0 05 01 07 00000004 07 0 00000001 ffffffff 1 01 07 03 00000c 1 06 f0f00f0f
1 0 00000041 1 06 01 08 00000100 08 0 00000010 deadbeef 1 02 08 03 000021 1 07 ffffffff
1 0 00000014 0 07 01 09 0000ffff 09 0 12345678 ffffffff 1 01 09 03 00000c 1 08 00000110
1 0 00000041 1 08 01 0a a0000000 0a 0 00000005 0f0f0f0f 1 02 0a 03 000021 1 09 00005678
1 0 00000014 0 16 01 0b 00000005 0b 0 00000001 00000024 1 01 0b 03 00000c 1 0a a0000005
1 0 00000041 1 17 01 0c 00000004 0c 0 80000000 00000004 1 02 0c 03 000021 1 0b 00000010
1 0 00000014 0 18 01 0d 00000004 0d 0 80000000 00000004 1 01 0d 03 00000c 1 0c 08000000
# register port not ready, write held without a stamp
3 0 00000001 0 18 01 0d 00000004 0d 0 00000000 00000000 0 00 00 00 000000 1 0d f8000000
1 0 00000001 0 18 01 0d 00000004 0d 0 00000000 00000000 1 00 00 01 000001 1 0d f8000000
# reset again so tags start from 0
2 1 00000000 0 00 00 00 00000000 00 0 00000000 00000000 1 00 00 00 000000 0 00 00000000
# 32 executes without writeback use tags 0 to 31
32 0 40000000 7 00 01 1f 00000002 00 4 00000007 00000009 1 80 00 80 800000 0 00 00000000
# every tag busy, execute stalls
2 0 40000000 7 00 01 1f 00000002 00 4 00000007 00000009 1 00 00 00 000000 0 00 00000000
# tag 0 written back from slot 3
1 0 40001000 3 00 01 1f 00000002 00 4 00000007 00000009 1 00 00 08 000a00 1 1f 00000010
# tag 0 is handed out again
1 0 40000000 7 00 01 1f 00000002 00 4 00000007 00000009 1 80 00 80 800000 0 00 00000000

/* alu_unit.sv */
// alu execution stage top, joins slot picking, datapath, result buffer and tag tracking
`timescale 1ns/1ps

module alu_unit (
    input  logic                                              clk,
    input  logic                                              rst,
    input  alu_pkg::stage_t [alu_pkg::num_slots-1:0]          slot_stage,
    input  alu_pkg::entry_t [alu_pkg::num_slots-1:0]          slot_entry,
    output logic [alu_pkg::reg_addr_w-1:0]                    rs_addr,
    input  logic [alu_pkg::data_w-1:0]                        rs_data,
    output logic [alu_pkg::reg_addr_w-1:0]                    rt_addr,
    input  logic [alu_pkg::data_w-1:0]                        rt_data,
    output logic [alu_pkg::reg_addr_w-1:0]                    wb_addr,
    output logic [alu_pkg::data_w-1:0]                        wb_data,
    output logic                                              wb_valid,
    input  logic                                              wb_ready,
    output alu_pkg::stamp_t [alu_pkg::num_slots-1:0]          stamp,
    output logic [alu_pkg::num_slots-1:0]                     stamp_valid,
    output logic [alu_pkg::num_slots-1:0][alu_pkg::tag_w-1:0] take_tag,
    output logic [alu_pkg::num_slots-1:0]                     take_valid
);

    logic                            exec_fire;
    logic [alu_pkg::slot_idx_w-1:0]  exec_slot;
    logic [alu_pkg::slot_idx_w-1:0]  wb_slot;
    logic [alu_pkg::tag_w-1:0]       next_tag;
    logic                            next_free;
    logic [alu_pkg::data_w-1:0]      result;
    logic                            wb_done;
    alu_pkg::entry_t                 exec_entry;
    alu_pkg::entry_t                 wb_entry;

    assign exec_entry = slot_entry[exec_slot];
    assign wb_entry   = slot_entry[wb_slot];
    assign wb_addr    = wb_entry.rd;
    assign wb_done    = wb_valid && wb_ready; // register write happens here

    alu_slot_select i_alu_slot_select (
        .slot_stage (slot_stage),
        .slot_entry (slot_entry),
        .exec_allow (next_free),
        .exec_fire  (exec_fire),
        .exec_slot  (exec_slot),
        .wb_pick    (wb_valid),
        .wb_slot    (wb_slot)
    );

    alu_datapath i_alu_datapath (
        .entry   (exec_entry),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .result  (result)
    );

    alu_result_buffer i_alu_result_buffer (
        .clk     (clk),
        .wr_en   (exec_fire),
        .wr_tag  (next_tag),
        .wr_data (result),
        .rd_tag  (wb_entry.tag),
        .rd_data (wb_data)
    );

    alu_tag_tracker i_alu_tag_tracker (
        .clk         (clk),
        .rst         (rst),
        .alloc       (exec_fire),
        .release_en  (wb_done),
        .release_tag (wb_entry.tag),
        .next_tag    (next_tag),
        .next_free   (next_free)
    );

    // per-slot fan-out of tag report and stamps
    always_comb begin
        for (int i = 0; i < alu_pkg::num_slots; i++) begin
            take_valid[i]  = exec_fire && exec_slot == i;
            take_tag[i]    = take_valid[i] ? next_tag : '0;
            stamp_valid[i] = 1'b0;
            stamp[i]       = '0;
            if (take_valid[i]) begin
                stamp_valid[i] = 1'b1;
                stamp[i]       = {1'b1, slot_entry[i].stamp[1:0]}; // executed
            end else if (wb_done && wb_slot == i) begin
                stamp_valid[i] = 1'b1;
                stamp[i]       = {slot_entry[i].stamp[2:1], 1'b1}; // written back
            end
        end
    end

endmodule

/* alu_unit_tb.sv */
// testbench for the alu execution stage that replays a trace of stimulus and expected outputs
`timescale 1ns/1ps

module alu_unit_tb;

    logic                                                 clk;
    logic                                                 rst;
    alu_pkg::stage_t [alu_pkg::num_slots-1:0]             slot_stage;
    alu_pkg::entry_t [alu_pkg::num_slots-1:0]             slot_entry;
    logic [alu_pkg::reg_addr_w-1:0]                       rs_addr;
    logic [alu_pkg::data_w-1:0]                           rs_data;
    logic [alu_pkg::reg_addr_w-1:0]                       rt_addr;
    logic [alu_pkg::data_w-1:0]                           rt_data;
    logic [alu_pkg::reg_addr_w-1:0]                       wb_addr;
    logic [alu_pkg::data_w-1:0]                           wb_data;
    logic                                                 wb_valid;
    logic                                                 wb_ready;
    alu_pkg::stamp_t [alu_pkg::num_slots-1:0]             stamp;
    logic [alu_pkg::num_slots-1:0]                        stamp_valid;
    logic [alu_pkg::num_slots-1:0][alu_pkg::tag_w-1:0]    take_tag;
    logic [alu_pkg::num_slots-1:0]                        take_valid;

    // stimulus part of one trace line
    int                               in_cnt;
    logic                             in_rst;
    logic [31:0]                      in_stages;    // one nibble per slot with slot 0 lowest
    int                               in_slot;      // slot whose entry this line rewrites
    logic [5:0]                       in_op;
    logic [alu_pkg::reg_addr_w-1:0]   in_rs;
    logic [alu_pkg::reg_addr_w-1:0]   in_rd;
    logic [alu_pkg::data_w-1:0]       in_operand;
    logic [alu_pkg::tag_w-1:0]        in_tag;
    logic [2:0]                       in_stamp;
    logic [alu_pkg::data_w-1:0]       in_rs_data;
    logic [alu_pkg::data_w-1:0]       in_rt_data;
    logic                             in_ready;

    // expected part
    logic [alu_pkg::num_slots-1:0]    exp_take_valid;
    logic [alu_pkg::tag_w-1:0]        exp_take_tag; // tag of the first repetition
    logic [alu_pkg::num_slots-1:0]    exp_stamp_valid;
    logic [3*alu_pkg::num_slots-1:0]  exp_stamp;
    logic                             exp_wb_valid;
    logic [alu_pkg::reg_addr_w-1:0]   exp_wb_addr;
    logic [alu_pkg::data_w-1:0]       exp_wb_data;

    int   errors;
    int   cycles;
    logic timed_out;

    alu_unit i_alu_unit (
        .clk         (clk),
        .rst         (rst),
        .slot_stage  (slot_stage),
        .slot_entry  (slot_entry),
        .rs_addr     (rs_addr),
        .rs_data     (rs_data),
        .rt_addr     (rt_addr),
        .rt_data     (rt_data),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .stamp       (stamp),
        .stamp_valid (stamp_valid),
        .take_tag    (take_tag),
        .take_valid  (take_valid)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic apply_inputs();
        rst = in_rst;
        for (int i = 0; i < alu_pkg::num_slots; i++) begin
            slot_stage[i] = in_stages[4*i +: 3];
        end
        if (in_slot >= 0 && in_slot < alu_pkg::num_slots) begin
            slot_entry[in_slot].opcode           = in_op;
            slot_entry[in_slot].rs               = in_rs;
            slot_entry[in_slot].rd               = in_rd;
            slot_entry[in_slot].operand.imm_form = in_operand;
            slot_entry[in_slot].tag              = in_tag;
            slot_entry[in_slot].stamp            = in_stamp;
        end
        rs_data  = in_rs_data;
        rt_data  = in_rt_data;
        wb_ready = in_ready;
    endtask

    task automatic check_outputs(input int rep);
        logic [alu_pkg::num_slots-1:0][alu_pkg::tag_w-1:0] exp_tt;
        int                                                exec_idx;
        exec_idx = -1;
        for (int i = 0; i < alu_pkg::num_slots; i++) begin
            // repeated executes take consecutive tags
            exp_tt[i] = exp_take_valid[i] ? exp_take_tag + rep[alu_pkg::tag_w-1:0] : '0;
            if (exp_take_valid[i]) begin
                exec_idx = i;
            end
        end
        check_value("take_valid", take_valid, exp_take_valid);
        check_value("take_tag", take_tag, exp_tt);
        check_value("stamp_valid", stamp_valid, exp_stamp_valid);
        check_value("stamp", stamp, exp_stamp);
        check_value("wb_valid", wb_valid, exp_wb_valid);
        if (exp_wb_valid) begin
            check_value("wb_addr", wb_addr, exp_wb_addr);
            check_value("wb_data", wb_data, exp_wb_data);
        end
        if (exec_idx >= 0) begin
            // register reads come from the executing slot
            check_value("rs_addr", rs_addr, slot_entry[exec_idx].rs);
            check_value("rt_addr", rt_addr, slot_entry[exec_idx].operand.reg_form.rt);
        end
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        clk        = 1'b0;
        rst        = 1'b1;
        slot_stage = '0;
        slot_entry = '0;
        rs_data    = '0;
        rt_data    = '0;
        wb_ready   = 1'b0;
        errors     = 0;
        cycles     = 0;
        timed_out  = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        fd = $fopen("alu_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file alu_trace.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                n = $sscanf(line, "%d %h %h %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            in_cnt, in_rst, in_stages, in_slot, in_op, in_rs, in_rd,
                            in_operand, in_tag, in_stamp, in_rs_data, in_rt_data, in_ready,
                            exp_take_valid, exp_take_tag, exp_stamp_valid, exp_stamp,
                            exp_wb_valid, exp_wb_addr, exp_wb_data);
                if (n <= 0) begin
                    continue; // comment or blank line
                end
                if (n != 20) begin
                    $display("malformed trace line, %0d fields: %s", n, line);
                    errors++;
                    continue;
                end
                for (int rep = 0; rep < in_cnt; rep++) begin
                    if (cycles >= 1000) begin
                        timed_out = 1'b1;
                        break;
                    end
                    apply_inputs();
                    #15;
                    check_outputs(rep); // just before the next edge
                    @(posedge clk);
                    #2;
                    cycles++;
                end
            end
            $fclose(fd);
        end
        if (timed_out) begin
            $display("trace replay did not finish within 1000 cycles");
        end
        $display("checks done after %0d cycles, errors %0d", cycles, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
alu_pkg.sv
alu_slot_select.sv
alu_datapath.sv
alu_result_buffer.sv
alu_tag_tracker.sv
alu_unit.sv
alu_unit_tb.sv
